// ==== tb.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/alu_exec.sv
hdl/exec_core.sv
test/exec_core_asserts.sv
test/exec_core_tb.sv

// ==== test/exec_core_tb.sv ====
`include "rv_macros.svh"

module exec_core_tb;

    import rv_pkg::*;

    logic             clk;
    logic             rstN;
    logic             instrValid;
    logic [`XLEN-1:0] instr;
    wbT               result;
    logic             illegalInstr;

    // Architectural reference, issue stream, expected results
    logic [`XLEN-1:0] refRegs [`REG_COUNT];
    logic [`XLEN-1:0] wordQ [$];
    wbT               expQ [$];
    int               expIllegal;
    int               errCount;
    int               checkCount;
    logic [31:0]      rngState;

    exec_core u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Encoders and reference model
    ////////////////////////////////////////

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic [31:0] encR(aluOpT op, logic [4:0] rd, logic [4:0] rs1,
                                         logic [4:0] rs2);
        logic [2:0] f3;
        case (op)
            aluSll:  f3 = 3'b001;
            aluSlt:  f3 = 3'b010;
            aluXor:  f3 = 3'b100;
            aluSrl:  f3 = 3'b101;
            aluOr:   f3 = 3'b110;
            aluAnd:  f3 = 3'b111;
            default: f3 = 3'b000;
        endcase
        // SUB is the only alternate funct7
        return {(op == aluSub) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // RV32I semantics with shifts by the low 5 bits
    function automatic logic [31:0] refOp(aluOpT op, logic [31:0] a, logic [31:0] b);
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSll:  return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    // Queue a word and its result, then update the reference
    task automatic expectWrite(logic [31:0] word, logic [4:0] rd, logic [31:0] data);
        wbT exp;
        exp.valid    = 1'b1;
        exp.regWrite = (rd != 5'd0);
        exp.rd       = rd;
        exp.data     = data;
        wordQ.push_back(word);
        expQ.push_back(exp);
        if (rd != 5'd0) begin
            refRegs[rd] = data;
        end
    endtask

    task automatic pushRType(aluOpT op, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        expectWrite(encR(op, rd, rs1, rs2), rd, refOp(op, refRegs[rs1], refRegs[rs2]));
    endtask

    task automatic loadAddi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        expectWrite({imm, rs1, 3'b000, rd, 7'b0010011}, rd,
                    refRegs[rs1] + {{20{imm[11]}}, imm});
    endtask

    task automatic markIllegal(logic [31:0] word);
        wordQ.push_back(word);
        expIllegal++;
    endtask

    ////////////////////////////////////////
    // Batch runner
    ////////////////////////////////////////

    // Words go out back to back with results matched in order
    task automatic runBatch();
        int idle;
        int waitCnt;
        int seenIllegal;
        bit issueDone;
        wbT exp;
        idle        = 0;
        waitCnt     = 0;
        seenIllegal = 0;
        issueDone   = 1'b0;
        fork
            begin
                foreach (wordQ[i]) begin
                    instrValid = 1'b1;
                    instr      = wordQ[i];
                    @(posedge clk);
                    #1;
                end
                instrValid = 1'b0;
                issueDone  = 1'b1;
            end
            // Sampled mid-cycle
            // Drain window catches stray results
            while (!issueDone || expQ.size() > 0 || idle < 4) begin
                @(negedge clk);
                seenIllegal += illegalInstr;
                waitCnt++;
                if (issueDone && !result.valid) idle++;
                if (result.valid) begin
                    idle = 0;
                    checkCount++;
                    assert (expQ.size() > 0)
                        else begin
                            errCount++;
                            $display("A result appeared with no instruction expecting one");
                        end
                    if (expQ.size() > 0) begin
                        waitCnt = 0;
                        exp     = expQ.pop_front();
                        assert (result == exp)
                            else begin
                                errCount++;
                                $display("Error: result got %h expected %h", result, exp);
                            end
                    end
                end
                if (waitCnt > 50) begin
                    $display("Timed out waiting for result.valid");
                    $display("Errors: %0d of %0d checks", errCount + 1, checkCount);
                    $display("SIMULATION FAILED");
                    $finish;
                end
            end
        join
        assert (seenIllegal == expIllegal)
            else begin
                errCount++;
                $display("Error: illegalInstr pulses got %h expected %h",
                         seenIllegal, expIllegal);
            end
        wordQ.delete();
        expQ.delete();
        expIllegal = 0;
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    // ADD xi, xi, x0 returns xi and leaves it as is
    task automatic readAll();
        for (int i = 0; i < `REG_COUNT; i++) begin
            pushRType(aluAdd, 5'(i), 5'(i), 5'd0);
        end
        runBatch();
    endtask

    task automatic checkResetClear();
        readAll();
    endtask

    // Random immediates into x1..x31
    task automatic loadImmediates();
        for (int i = 1; i < `REG_COUNT; i++) begin
            loadAddi(5'(i), 5'd0, 12'(nextRand()));
        end
        runBatch();
        readAll();
    endtask

    // Every op on fresh values and on older register contents
    task automatic exerciseAluOps();
        aluOpT op;
        op = aluAdd;
        repeat (8) begin
            loadAddi(5'd5, 5'd0, 12'(nextRand()));
            loadAddi(5'd6, 5'd0, 12'(nextRand()));
            pushRType(op, 5'd7, 5'd5, 5'd6);
            pushRType(op, 5'd20, 5'(1 + nextRand() % 31), 5'(1 + nextRand() % 31));
            op = op.next();
        end
        runBatch();
    endtask

    // Each instruction uses the one just before it
    task automatic chainDependent();
        loadAddi(5'd8, 5'd0, 12'(nextRand()));
        pushRType(aluAdd, 5'd9, 5'd8, 5'd8);
        pushRType(aluSub, 5'd10, 5'd9, 5'd8);
        pushRType(aluSll, 5'd8, 5'd10, 5'd9);
        loadAddi(5'd11, 5'd8, 12'(nextRand()));
        pushRType(aluSlt, 5'd12, 5'd11, 5'd10);
        runBatch();
        readAll();
    endtask

    // Writes to x0 dropped and never forwarded
    task automatic guardX0();
        loadAddi(5'd0, 5'd0, 12'(nextRand()));
        pushRType(aluAdd, 5'd14, 5'd0, 5'd0);
        pushRType(aluOr, 5'd0, 5'd3, 5'd4);
        pushRType(aluXor, 5'd15, 5'd0, 5'd3);
        runBatch();
    endtask

    // LW, XOR with alt funct7, SLTU, SLTI
    task automatic rejectIllegal();
        markIllegal({12'h004, 5'd1, 3'b010, 5'd3, 7'b0000011});
        markIllegal(encR(aluXor, 5'd4, 5'd1, 5'd2) | 32'h4000_0000);
        markIllegal({7'h00, 5'd2, 5'd1, 3'b011, 5'd5, 7'b0110011});
        markIllegal({12'h7ff, 5'd1, 3'b010, 5'd6, 7'b0010011});
        runBatch();
        readAll();
    endtask

    initial begin
        rngState   = 32'hf54b_54f1;
        errCount   = 0;
        checkCount = 0;
        expIllegal = 0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        foreach (refRegs[i]) begin
            refRegs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        checkResetClear();
        loadImmediates();
        exerciseAluOps();
        chainDependent();
        guardX0();
        rejectIllegal();
        $display("Errors: %0d of %0d checks", errCount, checkCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== test/exec_core_asserts.sv ====
module exec_core_asserts (
    input logic             clk,
    input logic             rstN,
    input logic             instrValid,
    input rv_pkg::wbT       result,
    input logic             illegalInstr
);

    import rv_pkg::*;

    // Known strobe and known payload whenever it is presented
    resultKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(result.valid) && (!result.valid || !$isunknown(result)))
        else $error("result carries unknown bits while valid");

    // Strobe at edge N shows up after edge N+1
    resultLatency: assert property (@(posedge clk) disable iff (!rstN)
        result.valid |-> $past(instrValid, 2))
        else $error("result.valid without a strobe two edges earlier");

    // Illegal encodings never reach the result
    illegalDropped: assert property (@(posedge clk) disable iff (!rstN)
        illegalInstr |=> !result.valid)
        else $error("result.valid followed an illegal instruction");

    // x0 never written
    noX0Write: assert property (@(posedge clk) disable iff (!rstN)
        result.regWrite |-> result.rd != '0)
        else $error("result.regWrite set with rd x0");

endmodule

bind exec_core exec_core_asserts u_asserts (.*);

// ==== hdl/exec_core.sv ====
`include "rv_macros.svh"

module exec_core (
    input  logic             clk,
    input  logic             rstN,
    input  logic             instrValid,
    input  logic [`XLEN-1:0] instr,
    output rv_pkg::wbT       result,
    output logic             illegalInstr
);

    import rv_pkg::*;

    ////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////

    decodedT            dec;
    wbT                 wb;
    logic [`REG_AW-1:0] rs1Addr;
    logic [`REG_AW-1:0] rs2Addr;
    logic [`XLEN-1:0]   rs1Data;
    logic [`XLEN-1:0]   rs2Data;

    ////////////////////////////////////////
    // Stages
    ////////////////////////////////////////

    // Producer, one instruction per strobe
    instr_decoder u_decoder (
        .clk          (clk),
        .rstN         (rstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .dec          (dec),
        .illegalInstr (illegalInstr)
    );

    // Architectural state, written from wb
    reg_file u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wb      (wb)
    );

    // Consumer with one-level forwarding
    alu_exec u_aluExec (
        .clk     (clk),
        .rstN    (rstN),
        .dec     (dec),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wb      (wb)
    );

    // Result is the writeback as seen by the register file
    assign result = wb;

endmodule

// ==== hdl/alu_exec.sv ====
`include "rv_macros.svh"

module alu_exec (
    input  logic               clk,
    input  logic               rstN,
    input  rv_pkg::decodedT    dec,
    output logic [`REG_AW-1:0] rs1Addr,
    output logic [`REG_AW-1:0] rs2Addr,
    input  logic [`XLEN-1:0]   rs1Data,
    input  logic [`XLEN-1:0]   rs2Data,
    output rv_pkg::wbT         wb
);

    import rv_pkg::*;

    ////////////////////////////////////////
    // Operand fetch
    ////////////////////////////////////////

    // Register file lookup straight from decoded sources
    assign rs1Addr = dec.rs1;
    assign rs2Addr = dec.rs2;

    logic             fwd1;
    logic             fwd2;
    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;

    // Older instruction in wb writes at the coming edge
    // regWrite already excludes x0
    assign fwd1 = wb.valid && wb.regWrite && (wb.rd == dec.rs1);
    assign fwd2 = wb.valid && wb.regWrite && (wb.rd == dec.rs2);

    assign src1 = fwd1 ? wb.data : rs1Data;
    assign src2 = fwd2 ? wb.data : rs2Data;

    // Immediate replaces rs2 for ADDI
    assign opA = src1;
    assign opB = dec.useImm ? dec.imm : src2;

    ////////////////////////////////////////
    // Compute
    ////////////////////////////////////////

    logic [`XLEN-1:0] aluOut;

    always_comb begin
        case (dec.aluOp)
            aluAdd:  aluOut = opA + opB;
            aluSub:  aluOut = opA - opB;
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluXor:  aluOut = opA ^ opB;
            // Signed compare, result is 0 or 1
            aluSlt:  aluOut = {{(`XLEN-1){1'b0}}, ($signed(opA) < $signed(opB))};
            // Shift amount from low 5 bits only
            aluSll:  aluOut = opA << opB[4:0];
            aluSrl:  aluOut = opA >> opB[4:0];
            default: aluOut = '0;
        endcase
    end

    ////////////////////////////////////////
    // Writeback register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wb <= '0;
        end else begin
            wb.valid    <= dec.valid;
            wb.regWrite <= dec.valid && dec.regWrite;
            wb.rd       <= dec.rd;
            wb.data     <= aluOut;
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
`include "rv_macros.svh"

module reg_file (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`REG_AW-1:0] rs1Addr,
    input  logic [`REG_AW-1:0] rs2Addr,
    output logic [`XLEN-1:0]   rs1Data,
    output logic [`XLEN-1:0]   rs2Data,
    input  rv_pkg::wbT         wb
);

    import rv_pkg::*;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // Storage for x1..x31 only
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    logic             wrEn;

    // Write strobe from the writeback stage
    assign wrEn = wb.valid && wb.regWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // Architectural state cleared
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.rd] <= wb.data;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Combinational reads with x0 hardwired to zero
    always_comb begin
        if (rs1Addr == '0) begin
            rs1Data = '0;
        end else begin
            rs1Data = regs[rs1Addr];
        end
    end

    always_comb begin
        if (rs2Addr == '0) begin
            rs2Data = '0;
        end else begin
            rs2Data = regs[rs2Addr];
        end
    end

endmodule

// ==== hdl/instr_decoder.sv ====
`include "rv_macros.svh"

module instr_decoder (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  logic [`XLEN-1:0]  instr,
    output rv_pkg::decodedT   dec,
    output logic              illegalInstr
);

    import rv_pkg::*;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Major opcodes
    localparam logic [6:0] OpReg = 7'b0110011;
    localparam logic [6:0] OpImm = 7'b0010011;

    // funct7 variants
    localparam logic [6:0] F7Base = 7'b0000000;
    localparam logic [6:0] F7Alt  = 7'b0100000;

    ////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [`RV_REG_FIELD-1:0] rdField;
    logic [`RV_REG_FIELD-1:0] rs1Field;
    logic [`RV_REG_FIELD-1:0] rs2Field;

    assign opcode   = instr[6:0];
    assign rdField  = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1Field = instr[19:15];
    assign rs2Field = instr[24:20];
    assign funct7   = instr[31:25];

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    logic    legal;
    decodedT decNext;

    always_comb begin
        legal          = 1'b0;
        decNext        = '0;
        decNext.rs1    = rs1Field;
        decNext.rs2    = rs2Field;
        decNext.rd     = rdField;
        // I-immediate, sign bit replicated up
        decNext.imm    = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        decNext.aluOp  = aluAdd;
        case (opcode)
            OpReg: begin
                legal = 1'b1;
                case (funct3)
                    3'b000: begin
                        // ADD and SUB share funct3
                        if (funct7 == F7Alt) decNext.aluOp = aluSub;
                        else decNext.aluOp = aluAdd;
                        legal = (funct7 == F7Base) || (funct7 == F7Alt);
                    end
                    3'b001: decNext.aluOp = aluSll;
                    3'b010: decNext.aluOp = aluSlt;
                    3'b100: decNext.aluOp = aluXor;
                    3'b101: decNext.aluOp = aluSrl;
                    3'b110: decNext.aluOp = aluOr;
                    3'b111: decNext.aluOp = aluAnd;
                    default: legal = 1'b0;  // SLTU not supported
                endcase
                // Non-ADD/SUB ops only accept base funct7
                if (funct3 != 3'b000 && funct7 != F7Base) legal = 1'b0;
            end
            OpImm: begin
                // ADDI only
                legal          = (funct3 == 3'b000);
                decNext.useImm = 1'b1;
                decNext.rs2    = '0;  // Field holds immediate bits
            end
            default: legal = 1'b0;
        endcase
        decNext.regWrite = (rdField != '0);
        decNext.valid    = instrValid && legal;
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dec          <= '0;
            illegalInstr <= 1'b0;
        end else begin
            dec          <= decNext;
            // One-cycle pulse, no dec.valid alongside
            illegalInstr <= instrValid && !legal;
        end
    end

endmodule

// ==== hdl/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

    ////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////

    // One code per supported operation
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5,
        aluSll = 3'd6,
        aluSrl = 3'd7
    } aluOpT;

    ////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////

    // Decoder to execute
    typedef struct packed {
        logic                valid;
        aluOpT               aluOp;
        logic [`REG_AW-1:0]  rs1;
        logic [`REG_AW-1:0]  rs2;
        logic [`REG_AW-1:0]  rd;
        logic                useImm;
        logic [`XLEN-1:0]    imm;       // Sign-extended I-immediate
        logic                regWrite;  // Low when rd is x0
    } decodedT;

    // Execute to register file and top-level result
    typedef struct packed {
        logic                valid;
        logic                regWrite;
        logic [`REG_AW-1:0]  rd;
        logic [`XLEN-1:0]    data;
    } wbT;

endpackage

// ==== hdl/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

////////////////////////////////////////
// Core dimensions
////////////////////////////////////////

// Data word width of one RV32I register
`define XLEN 32

// Architectural register count including x0
`define REG_COUNT 32

// Register address width as log2 of the count
`define REG_AW 5

////////////////////////////////////////
// Instruction field widths
////////////////////////////////////////

// Register field width in the instruction word
`define RV_REG_FIELD 5

`endif
